// File: verilog.f
+incdir+src
src/qTablePkg.sv
src/stageIf.sv
src/packetIntake.sv
src/neighborSearch.sv
src/entryWriter.sv
src/neighborTable.sv
src/qTableTop.sv
test/qTableChecker.sv
test/qTableTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the neighbor-table testbench with verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module qTableTb -o simQTable
./obj_dir/simQTable | tee sim.log

# verdict comes from the log, not the exit code
if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: test/qTableTb.sv
`timescale 1ns/1ps
`include "qTableDefs.svh"

// drives feedback and announce packets into the neighbor-table path
module qTableTb import qTablePkg::*; ();

    localparam int DoneTimeout = 200;     // full table walk is ~2 cycles per entry

    logic                   clock;
    logic                   nrst;
    logic                   en;
    logic [2:0]             packetType;
    neighborEntry           pkt;          // fields of the packet on the inputs
    logic                   done;
    logic                   overrun;
    logic [1:0]             result;
    logic [`TABLE_AW-1:0]   entryIndex;
    logic [`WORD_WIDTH-1:0] nodeId;
    logic [`WORD_WIDTH-1:0] nodeClusterId;
    logic [`WORD_WIDTH-1:0] nodeEnergy;
    logic [`WORD_WIDTH-1:0] nodeQValue;
    logic [`WORD_WIDTH-1:0] neighborCount;
    int                     errorCount;   // from the checker
    int                     overrunCount;
    int                     doneCount;
    int                     refusedCount;
    logic [31:0]            lfsr;
    int                     tbErrors;
    int                     timeouts;
    int                     overrunsBefore;
    int                     donesBefore;
    int                     i;

    qTableTop DUT (
        .clock(clock), .nrst(nrst), .en(en),
        .fSourceId(pkt.nodeId), .fClusterId(pkt.clusterId),
        .fEnergyLeft(pkt.energy), .fQValue(pkt.qValue), .packetType(packetType),
        .done(done), .overrun(overrun), .result(result), .entryIndex(entryIndex),
        .nodeId(nodeId), .nodeClusterId(nodeClusterId), .nodeEnergy(nodeEnergy),
        .nodeQValue(nodeQValue), .neighborCount(neighborCount)
    );

    qTableChecker refCheck (
        .clock(clock), .nrst(nrst),
        .sent(en), .sentType(packetType), .sentEntry(pkt),
        .done(done), .overrun(overrun), .result(result), .entryIndex(entryIndex),
        .nodeId(nodeId), .nodeClusterId(nodeClusterId), .nodeEnergy(nodeEnergy),
        .nodeQValue(nodeQValue), .neighborCount(neighborCount),
        .errorCount(errorCount), .overrunCount(overrunCount),
        .doneCount(doneCount), .refusedCount(refusedCount)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // galois lfsr, one step per bit handed out
    function automatic logic [15:0] randomBits(input int n);
        logic [15:0] bits;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            bits = {bits[14:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return bits;
    endfunction

    task automatic idleCycles(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(posedge clock);
            #1;                             // stay 1 ns past the edge
        end
    endtask

    // one-cycle strobe, entered and left 1 ns after an edge
    task automatic sendPacket(input logic [2:0] kind, input logic [15:0] id);
        packetType    = kind;
        pkt.nodeId    = id;
        pkt.clusterId = randomBits(16);
        pkt.energy    = randomBits(16);
        pkt.qValue    = randomBits(16);
        en = 1'b1;
        @(posedge clock);
        #1;
        en = 1'b0;
    endtask

    task automatic waitForDone();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clock);
            #1;
            cycles++;
        end while (done !== 1'b1 && cycles < DoneTimeout);
        if (done !== 1'b1) begin
            $display("t=%0t timed out waiting for done after %0d cycles", $time, cycles);
            timeouts++;
        end
    endtask

    // mixed kinds over a small id pool so repeats happen
    task automatic randomMix(input int n);
        packetKind kind;
        int        k;
        for (k = 0; k < n; k++) begin
            case (randomBits(2))
                16'd0, 16'd1: kind = pktFeedback;
                16'd2:        kind = pktHeadAnnounce;
                default:      kind = pktOther;
            endcase
            sendPacket(kind, 16'd300 + randomBits(4));
            if (kind == pktOther)
                idleCycles(4);
            else
                waitForDone();
            idleCycles(randomBits(2));      // spacing 0..3 cycles
        end
    endtask

    initial begin
        lfsr       = 32'h8183;
        nrst       = 1'b0;
        en         = 1'b0;
        packetType = 3'd0;
        pkt        = '0;
        tbErrors   = 0;
        timeouts   = 0;
        idleCycles(5);
        nrst = 1'b1;
        if (done !== 1'b0 || overrun !== 1'b0 || neighborCount !== '0) begin
            $display("FAIL t=%0t done/overrun/neighborCount expected 0/0/0 got %b/%b/%0d",
                     $time, done, overrun, neighborCount);
            tbErrors++;
        end
        for (i = 0; i < 6; i++) begin       // fresh ids appended in order
            sendPacket(pktFeedback, 16'd100 + i[15:0]);
            waitForDone();
        end
        sendPacket(pktFeedback, 16'd102);   // full rewrite at index 2
        waitForDone();
        sendPacket(pktHeadAnnounce, 16'd103);  // keeps stored q
        waitForDone();
        sendPacket(pktHeadAnnounce, 16'd106);  // new, q forced to zero
        waitForDone();
        for (i = 0; i < 8; i++) begin       // ignored codes, no done expected
            if (i != 1 && i != 2) begin
                sendPacket(i[2:0], 16'd101);
                idleCycles(20);
            end
        end
        overrunsBefore = overrunCount;
        donesBefore    = doneCount;
        sendPacket(pktFeedback, 16'd104);   // three strobes back to back
        sendPacket(pktFeedback, 16'd107);
        sendPacket(pktFeedback, 16'd108);   // third one lost
        waitForDone();
        waitForDone();
        idleCycles(DoneTimeout);
        if (overrunCount - overrunsBefore != 1 || doneCount - donesBefore != 2) begin
            $display("t=%0t back-to-back burst gave %0d overruns and %0d dones, wanted 1 and 2",
                     $time, overrunCount - overrunsBefore, doneCount - donesBefore);
            tbErrors++;
        end
        randomMix(60);
        for (i = 0; i < 40; i++) begin      // overfill, tail gets refused
            sendPacket(pktFeedback, 16'd400 + i[15:0]);
            waitForDone();
        end
        sendPacket(pktHeadAnnounce, 16'd100);  // updates still work when full
        waitForDone();
        sendPacket(pktFeedback, 16'd400);
        waitForDone();
        randomMix(20);
        idleCycles(10);
        if (refusedCount == 0) begin
            $display("t=%0t table never refused a packet after overfilling", $time);
            tbErrors++;
        end
        $display("errors: %0d timeouts: %0d", tbErrors + errorCount, timeouts);
        if (tbErrors + errorCount == 0 && timeouts == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: test/qTableChecker.sv
`timescale 1ns/1ps
`include "qTableDefs.svh"

// reference table model, compared against the DUT on every done
module qTableChecker import qTablePkg::*; (
    input  logic                   clock,
    input  logic                   nrst,
    input  logic                   sent,          // mirrors en from the tb
    input  logic [2:0]             sentType,
    input  neighborEntry           sentEntry,
    input  logic                   done,
    input  logic                   overrun,
    input  logic [1:0]             result,
    input  logic [`TABLE_AW-1:0]   entryIndex,
    input  logic [`WORD_WIDTH-1:0] nodeId,
    input  logic [`WORD_WIDTH-1:0] nodeClusterId,
    input  logic [`WORD_WIDTH-1:0] nodeEnergy,
    input  logic [`WORD_WIDTH-1:0] nodeQValue,
    input  logic [`WORD_WIDTH-1:0] neighborCount,
    output int                     errorCount,
    output int                     overrunCount,
    output int                     doneCount,
    output int                     refusedCount
);

    typedef struct packed {
        logic [2:0]   kind;
        neighborEntry entry;
    } sentPacket;

    typedef struct packed {
        searchResult          res;
        logic [`TABLE_AW-1:0] idx;
        neighborEntry         entry;   // what the node outputs should show
    } expectation;

    neighborEntry refTable [`TABLE_DEPTH];
    int           refCount;
    sentPacket    pending [$];         // accepted, not yet done
    sentPacket    head;
    expectation   want;

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
            errorCount++;
        end
    endtask

    // table rules applied to one packet, model left untouched
    function automatic expectation predict(input logic [2:0] kind, input neighborEntry pkt);
        expectation e;
        int         hitAt;
        int         i;
        hitAt   = -1;
        e.entry = pkt;
        for (i = 0; i < refCount; i++)
            if (hitAt < 0 && refTable[i].nodeId == pkt.nodeId)
                hitAt = i;                           // first match wins
        if (hitAt >= 0) begin
            e.res = resUpdated;
            e.idx = hitAt[`TABLE_AW-1:0];
            if (kind == pktHeadAnnounce)
                e.entry.qValue = refTable[hitAt].qValue;  // learned q survives
        end else if (refCount == `TABLE_DEPTH) begin
            e.res = resFull;                         // refused packet shown raw
            e.idx = '0;
        end else begin
            e.res = resAdded;
            e.idx = refCount[`TABLE_AW-1:0];
            if (kind == pktHeadAnnounce)
                e.entry.qValue = '0;                 // announce brings no q
        end
        return e;
    endfunction

    always @(posedge clock) begin
        if (!nrst) begin
            refCount     = 0;
            errorCount   = 0;
            overrunCount = 0;
            doneCount    = 0;
            refusedCount = 0;
            pending.delete();
        end else begin
            if (done) begin
                doneCount++;
                if (result == resFull)
                    refusedCount++;                  // refusals as the DUT reports them
                if (pending.size() == 0) begin
                    $display("t=%0t done pulsed with no accepted packet outstanding", $time);
                    errorCount++;
                end else begin
                    head = pending.pop_front();      // dones come in arrival order
                    want = predict(head.kind, head.entry);
                    compareField("result", 32'(want.res), 32'(result));
                    if (want.res != resFull)
                        compareField("entryIndex", 32'(want.idx), 32'(entryIndex));
                    compareField("nodeId", 32'(want.entry.nodeId), 32'(nodeId));
                    compareField("nodeClusterId", 32'(want.entry.clusterId), 32'(nodeClusterId));
                    compareField("nodeEnergy", 32'(want.entry.energy), 32'(nodeEnergy));
                    compareField("nodeQValue", 32'(want.entry.qValue), 32'(nodeQValue));
                    if (want.res != resFull)
                        refTable[want.idx] = want.entry;
                    if (want.res == resAdded)
                        refCount++;
                    compareField("neighborCount", 32'(refCount), 32'(neighborCount));
                end
            end
            if (overrun) begin
                overrunCount++;
                if (pending.size() == 0) begin
                    $display("t=%0t overrun pulsed with no packet in flight", $time);
                    errorCount++;
                end else begin
                    void'(pending.pop_back());       // newest packet was the dropped one
                end
            end
            // pktOther and unknown codes never reach the table
            if (sent && (sentType == pktFeedback || sentType == pktHeadAnnounce))
                pending.push_back(sentPacket'{sentType, sentEntry});
        end
    end

endmodule

// File: src/qTableTop.sv
`timescale 1ns/1ps
`include "qTableDefs.svh"

// neighbor-table update path: intake -> search -> writer
module qTableTop import qTablePkg::*; (
    input  logic                   clock,
    input  logic                   nrst,
    input  logic                   en,             // packet strobe
    input  logic [`WORD_WIDTH-1:0] fSourceId,
    input  logic [`WORD_WIDTH-1:0] fClusterId,
    input  logic [`WORD_WIDTH-1:0] fEnergyLeft,
    input  logic [`WORD_WIDTH-1:0] fQValue,
    input  logic [2:0]             packetType,
    output logic                   done,
    output logic                   overrun,        // packet dropped at intake
    output logic [1:0]             result,
    output logic [`TABLE_AW-1:0]   entryIndex,
    output logic [`WORD_WIDTH-1:0] nodeId,
    output logic [`WORD_WIDTH-1:0] nodeClusterId,
    output logic [`WORD_WIDTH-1:0] nodeEnergy,
    output logic [`WORD_WIDTH-1:0] nodeQValue,
    output logic [`WORD_WIDTH-1:0] neighborCount
);

    logic [`TABLE_AW-1:0] readAddr;
    neighborEntry         readEntry;
    logic                 writeEn;
    logic [`TABLE_AW-1:0] writeAddr;
    neighborEntry         writeEntry;

    stageIf intakeToSearch ();
    stageIf searchToWriter ();

    packetIntake uIntake (
        .clock       (clock),
        .nrst        (nrst),
        .en          (en),
        .fSourceId   (fSourceId),
        .fClusterId  (fClusterId),
        .fEnergyLeft (fEnergyLeft),
        .fQValue     (fQValue),
        .packetType  (packetType),
        .overrun     (overrun),
        .out         (intakeToSearch)
    );

    neighborSearch uSearch (
        .clock     (clock),
        .nrst      (nrst),
        .in        (intakeToSearch),
        .out       (searchToWriter),
        .count     (neighborCount),    // level from writer
        .readAddr  (readAddr),
        .readEntry (readEntry)
    );

    entryWriter uWriter (
        .clock         (clock),
        .nrst          (nrst),
        .in            (searchToWriter),
        .writeEn       (writeEn),
        .writeAddr     (writeAddr),
        .writeEntry    (writeEntry),
        .count         (neighborCount),
        .done          (done),
        .result        (result),
        .entryIndex    (entryIndex),
        .nodeId        (nodeId),
        .nodeClusterId (nodeClusterId),
        .nodeEnergy    (nodeEnergy),
        .nodeQValue    (nodeQValue)
    );

    neighborTable uTable (
        .clock      (clock),
        .readAddr   (readAddr),
        .readEntry  (readEntry),
        .writeEn    (writeEn),
        .writeAddr  (writeAddr),
        .writeEntry (writeEntry)
    );

endmodule

// File: src/neighborTable.sv
`timescale 1ns/1ps
`include "qTableDefs.svh"

// neighbor storage, one read port and one write port
module neighborTable import qTablePkg::*; (
    input  logic                 clock,
    input  logic [`TABLE_AW-1:0] readAddr,
    output neighborEntry         readEntry,
    input  logic                 writeEn,
    input  logic [`TABLE_AW-1:0] writeAddr,
    input  neighborEntry         writeEntry
);

    neighborEntry mem [`TABLE_DEPTH];   // only [0, count) ever read

    // write port
    always_ff @(posedge clock) begin
        if (writeEn)
            mem[writeAddr] <= writeEntry;
    end

    // registered read, old data on same-address collision
    always_ff @(posedge clock) begin
        readEntry <= mem[readAddr];
    end

    // maps onto block ram
    // search never reads the slot being written
    // since it starts only after the writer is done

endmodule

// File: src/entryWriter.sv
`timescale 1ns/1ps
`include "qTableDefs.svh"

// merges packet into entry, writes table, owns neighbor count
module entryWriter import qTablePkg::*; (
    input  logic                   clock,
    input  logic                   nrst,
    stageIf.sink                   in,
    output logic                   writeEn,
    output logic [`TABLE_AW-1:0]   writeAddr,
    output neighborEntry           writeEntry,
    output logic [`WORD_WIDTH-1:0] count,
    output logic                   done,
    output logic [1:0]             result,
    output logic [`TABLE_AW-1:0]   entryIndex,
    output logic [`WORD_WIDTH-1:0] nodeId,
    output logic [`WORD_WIDTH-1:0] nodeClusterId,
    output logic [`WORD_WIDTH-1:0] nodeEnergy,
    output logic [`WORD_WIDTH-1:0] nodeQValue
);

    logic         xfer;
    neighborEntry merged;
    neighborEntry shown;

    // busy only while the registered write is pending
    assign in.take = in.valid && !writeEn;
    assign xfer    = in.valid && in.take;

    always_comb begin
        merged = in.entry;                              // feedback takes all fields
        if (in.kind == pktHeadAnnounce) begin
            if (in.result == resUpdated)
                merged.qValue = in.stored.qValue;       // keep learned q
            else
                merged.qValue = '0;                     // fresh neighbor
        end
    end

    // refused packet is shown as it arrived
    assign shown = (in.result == resFull) ? in.entry : merged;

    always_ff @(posedge clock) begin
        if (!nrst) begin
            writeEn <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done    <= xfer;                            // one-cycle pulse
            writeEn <= xfer && (in.result != resFull);
            if (xfer && in.result == resAdded)
                count <= count + 1'b1;
        end
    end

    // payload, no reset
    always_ff @(posedge clock) begin
        if (xfer) begin
            writeAddr     <= in.index;
            writeEntry    <= merged;
            result        <= in.result;
            entryIndex    <= in.index;
            nodeId        <= shown.nodeId;
            nodeClusterId <= shown.clusterId;
            nodeEnergy    <= shown.energy;
            nodeQValue    <= shown.qValue;
        end
    end

    // table write lands on the edge that ends done
    // so the next search, taken no earlier, sees it

endmodule

// File: src/neighborSearch.sv
`timescale 1ns/1ps
`include "qTableDefs.svh"

// linear walk of the table, one compare per entry
module neighborSearch import qTablePkg::*; (
    input  logic                   clock,
    input  logic                   nrst,
    stageIf.sink                   in,
    stageIf.source                 out,
    input  logic [`WORD_WIDTH-1:0] count,      // neighbors currently stored
    output logic [`TABLE_AW-1:0]   readAddr,
    input  neighborEntry           readEntry   // valid one cycle after readAddr
);

    searchState             state;
    logic [`TABLE_AW:0]     idx;        // one extra bit, reaches TABLE_DEPTH
    logic [`WORD_WIDTH-1:0] idxWide;
    logic                   atEnd;
    logic                   full;
    logic                   hit;
    packetKind              pktKind;
    neighborEntry           pkt;
    neighborEntry           stored;
    searchResult            res;

    assign idxWide = {{(`WORD_WIDTH-`TABLE_AW-1){1'b0}}, idx};
    assign atEnd   = (idxWide == count);                    // walked past last entry
    assign full    = (count == `WORD_WIDTH'(`TABLE_DEPTH));
    assign hit     = (readEntry.nodeId == pkt.nodeId);

    // accept a packet only when idle
    assign in.take = (state == sIdle) && in.valid;

    assign readAddr = idx[`TABLE_AW-1:0];   // registered read lands in sCompare

    // control
    always_ff @(posedge clock) begin
        if (!nrst) begin
            state <= sIdle;
        end else begin
            case (state)
                sIdle: begin
                    if (in.valid)
                        state <= sCheckCount;
                end
                sCheckCount: begin
                    if (atEnd)
                        state <= sReport;    // add or refuse
                    else
                        state <= sCompare;   // address already out
                end
                sCompare: begin
                    if (hit)
                        state <= sReport;
                    else
                        state <= sCheckCount;
                end
                sReport: begin
                    if (out.take)
                        state <= sIdle;
                end
                default: state <= sIdle;
            endcase
        end
    end

    // packet, index and result registers
    always_ff @(posedge clock) begin
        case (state)
            sIdle: begin
                if (in.valid) begin
                    pktKind <= in.kind;
                    pkt     <= in.entry;
                    idx     <= '0;           // start at first neighbor
                end
            end
            sCheckCount: begin
                if (atEnd)
                    res <= full ? resFull : resAdded;
            end
            sCompare: begin
                if (hit) begin
                    res    <= resUpdated;
                    stored <= readEntry;     // writer may keep its q value
                end else begin
                    idx <= idx + 1'b1;
                end
            end
            default: ;
        endcase
    end

    // result pulse toward the writer
    assign out.valid  = (state == sReport);
    assign out.kind   = pktKind;
    assign out.entry  = pkt;
    assign out.stored = stored;
    assign out.index  = idx[`TABLE_AW-1:0];  // don't care on resFull
    assign out.result = res;

endmodule

// File: src/packetIntake.sv
`timescale 1ns/1ps
`include "qTableDefs.svh"

// one-deep intake slot in front of the search
module packetIntake import qTablePkg::*; (
    input  logic                   clock,
    input  logic                   nrst,
    input  logic                   en,
    input  logic [`WORD_WIDTH-1:0] fSourceId,
    input  logic [`WORD_WIDTH-1:0] fClusterId,
    input  logic [`WORD_WIDTH-1:0] fEnergyLeft,
    input  logic [`WORD_WIDTH-1:0] fQValue,
    input  logic [2:0]             packetType,
    output logic                   overrun,
    stageIf.source                 out
);

    packetKind    kind;
    logic         accepted;
    logic         slotValid;
    logic         capture;
    packetKind    slotKind;
    neighborEntry slotEntry;

    assign kind     = packetKind'(packetType);
    assign accepted = (kind == pktFeedback) || (kind == pktHeadAnnounce);
    // room if slot empty or being emptied on this edge
    assign capture  = en && accepted && (!slotValid || out.take);

    always_ff @(posedge clock) begin
        if (!nrst) begin
            slotValid <= 1'b0;
            overrun   <= 1'b0;
        end else begin
            overrun <= en && accepted && slotValid && !out.take;  // packet lost
            if (capture)
                slotValid <= 1'b1;
            else if (out.take)
                slotValid <= 1'b0;
        end
    end

    // payload, only meaningful while slotValid
    always_ff @(posedge clock) begin
        if (capture) begin
            slotKind  <= kind;
            slotEntry <= '{fSourceId, fClusterId, fEnergyLeft, fQValue};
        end
    end

    assign out.valid  = slotValid;
    assign out.kind   = slotKind;
    assign out.entry  = slotEntry;
    // search fills these in later
    assign out.stored = '0;
    assign out.index  = '0;
    assign out.result = resUpdated;

endmodule

// File: src/stageIf.sv
`timescale 1ns/1ps
`include "qTableDefs.svh"

// one packet plus its search result, passed stage to stage
interface stageIf import qTablePkg::*; ();

    logic                   valid;   // item waiting at source
    logic                   take;    // sink accepts this cycle
    packetKind              kind;
    neighborEntry           entry;   // fields from the packet
    neighborEntry           stored;  // entry read from table on a hit
    logic [`TABLE_AW-1:0]   index;   // table slot of hit or append
    searchResult            result;

    // item moves on an edge with valid and take both high
    modport source (
        output valid, kind, entry, stored, index, result,
        input  take
    );

    modport sink (
        input  valid, kind, entry, stored, index, result,
        output take
    );

endinterface

// File: src/qTablePkg.sv
`include "qTableDefs.svh"

package qTablePkg;

    // packet kinds seen on packetType, codes are fixed
    typedef enum logic [2:0] {
        pktFeedback     = 3'd1,   // replaces every field
        pktHeadAnnounce = 3'd2,   // cluster and energy only
        pktOther        = 3'd7    // anything else, ignored at intake
    } packetKind;

    // outcome of one table search
    typedef enum logic [1:0] {
        resUpdated = 2'd0,        // id found, entry rewritten
        resAdded   = 2'd1,        // new entry appended
        resFull    = 2'd2         // no room, packet refused
    } searchResult;

    // neighborSearch FSM
    typedef enum logic [2:0] {
        sIdle       = 3'd0,
        sCheckCount = 3'd1,       // end of table reached?
        sCompare    = 3'd2,       // read data back, compare ids
        sReport     = 3'd3        // hand result to writer
    } searchState;

    // one neighbor as stored in the table
    typedef struct packed {
        logic [`WORD_WIDTH-1:0] nodeId;
        logic [`WORD_WIDTH-1:0] clusterId;
        logic [`WORD_WIDTH-1:0] energy;
        logic [`WORD_WIDTH-1:0] qValue;
    } neighborEntry;

endpackage

// File: src/qTableDefs.svh
`ifndef QTABLE_DEFS_SVH
`define QTABLE_DEFS_SVH

// field width shared by id, cluster, energy, q value and count
`define WORD_WIDTH 16

// max neighbors the node tracks
`define TABLE_DEPTH 32

// address bits for TABLE_DEPTH entries
`define TABLE_AW 5

// result and kind codes live in qTablePkg
// count is a full word so it can reach TABLE_DEPTH

`endif
